//--- alu.sv
/* Purely combinational, no overflow traps. Shifts act on b; lui moves the low
   half of b to the upper half */
`timescale 1ns/10ps

module alu (
    input  isaPkg::aluOp_t aluOp,
    // a is rs, b is rt or the extended immediate
    input  isaPkg::word_t  a,
    input  isaPkg::word_t  b,
    // Fixed shamt field or rs[4:0] for variable shifts
    input  isaPkg::shamt_t shamt,
    output isaPkg::word_t  result
);
    import isaPkg::*;

    always_comb begin
        case (aluOp)
            // Wrapping two's complement, ADDU/SUBU/ADDIU and address calc
            ALU_ADD: result = a + b;
            ALU_SUB: result = a - b;

            // Bitwise
            ALU_AND: result = a & b;
            ALU_OR:  result = a | b;
            ALU_XOR: result = a ^ b;

            // Set on less than, 1 or 0
            ALU_SLT:  result = word_t'($signed(a) < $signed(b));
            ALU_SLTU: result = word_t'(a < b);

            // Shifts of b
            ALU_SLL: result = b << shamt;
            ALU_SRL: result = b >> shamt;
            // Sign bit fills from the left
            ALU_SRA: result = word_t'($signed(b) >>> shamt);

            // Immediate into the upper half, lower half cleared
            ALU_LUI: result = {b[15:0], 16'h0000};

            default: result = '0;
        endcase
    end

endmodule

//--- busChecker.sv
/* Watches the Avalon ports at the falling edge, where everything is stable.
   Expected stores come from the vectors image: header, program, data, pairs */
`timescale 1ns/10ps
`include "cpu_params.svh"

module busChecker (
    input  logic            clk,
    input  logic            reset,
    input  busPkg::busReq_t busReq,
    input  logic            waitrequest,
    input  logic            active,
    input  isaPkg::word_t   register_v0,
    // Whole vectors image, trailer found through the header counts
    input  isaPkg::word_t   vec [0:255],
    output int              checkCount,
    output int              errorCount,
    output logic            done
);
    import isaPkg::*;
    import busPkg::*;

    int      storeIndex;
    logic    seenFirst;
    logic    stalled;
    busReq_t heldReq;

    task automatic passed(input string name);
        checkCount++;
        $display("ok: %s", name);
    endtask

    task automatic failed(input string what);
        checkCount++;
        errorCount++;
        $display("%s", what);
    endtask

    // Completed write against the next expected pair
    task automatic checkStore();
        int    base;
        word_t expAddr;
        word_t expData;
        logic  good;
        base = 4 + int'(vec[0]) + int'(vec[1]) + 2 * storeIndex;
        if (storeIndex >= int'(vec[2])) begin
            failed($sformatf("extra store at address %h beyond the expected %0d",
                             busReq.address, vec[2]));
        end else begin
            expAddr = vec[base];
            expData = vec[base + 1];
            good    = 1'b1;
            if (busReq.address != expAddr) begin
                $display("mismatch address: got %h, expected %h", busReq.address, expAddr);
                good = 1'b0;
            end
            if (busReq.writedata != expData) begin
                $display("mismatch writedata: got %h, expected %h",
                         busReq.writedata, expData);
                good = 1'b0;
            end
            if (busReq.byteenable != 4'hF) begin
                $display("mismatch byteenable: got %h, expected %h", busReq.byteenable, 4'hF);
                good = 1'b0;
            end
            if (good) begin
                passed($sformatf("store %0d at %h", storeIndex, expAddr));
            end else begin
                failed($sformatf("store %0d failed", storeIndex));
            end
        end
        storeIndex++;
    endtask

    // End of program, v0 and the store count
    task automatic checkHalt();
        if (busReq.read || busReq.write) begin
            failed("bus still requesting after active fell");
        end
        if (register_v0 != vec[3]) begin
            $display("mismatch register_v0: got %h, expected %h", register_v0, vec[3]);
            failed("final v0 wrong");
        end else if (storeIndex != int'(vec[2])) begin
            failed($sformatf("core made %0d stores but %0d were expected",
                             storeIndex, vec[2]));
        end else begin
            passed("halt, v0 and store count");
        end
    endtask

    initial begin
        checkCount = 0;
        errorCount = 0;
        done       = 1'b0;
        storeIndex = 0;
        seenFirst  = 1'b0;
        stalled    = 1'b0;
        heldReq    = '0;
    end

    always @(negedge clk) begin
        if (reset) begin
            stalled   = 1'b0;
            seenFirst = 1'b0;
        end else begin
            if (busReq.read && busReq.write) begin
                failed("read and write high in the same cycle");
            end
            // Stalled request must not move
            if (stalled && (busReq != heldReq)) begin
                failed($sformatf("request changed under waitrequest, address %h",
                                 heldReq.address));
            end
            stalled = (busReq.read || busReq.write) && waitrequest;
            heldReq = busReq;

            // First transfer is the boot fetch
            if (!seenFirst && (busReq.read || busReq.write)) begin
                seenFirst = 1'b1;
                if (!busReq.read || busReq.address != `RESET_VECTOR) begin
                    $display("mismatch address: got %h, expected %h",
                             busReq.address, `RESET_VECTOR);
                    failed("first transfer is not a fetch from the reset vector");
                end else begin
                    passed("first fetch from reset vector");
                end
            end

            if (busReq.write && !waitrequest) begin
                checkStore();
            end

            if (!active && !done) begin
                done = 1'b1;
                checkHalt();
            end else if (done && (busReq.read || busReq.write)) begin
                failed("bus request seen after halt");
            end
        end
    end

endmodule

//--- busPkg.sv
/* Avalon master fields only; waitrequest and readdata come from the slave.
   byteenable stays all ones since only full words move */
package busPkg;

    // One bit per byte lane, bit 0 is the low byte
    typedef logic [3:0] byteEnable_t;

    // Everything the master drives, 70 bits
    typedef struct packed {
        // Word address, low two bits always zero
        isaPkg::word_t address;
        logic          read;
        logic          write;
        // Store data, ignored by the slave on reads
        isaPkg::word_t writedata;
        byteEnable_t   byteenable;
    } busReq_t;

endpackage

//--- controlUnit.sv
/* No delay slots, branches and jumps redirect at once. Only aligned LW/SW, and
   programs must not name register 0 as a destination (no NOPs) */
`timescale 1ns/10ps
`include "cpu_params.svh"

module controlUnit (
    input  logic              clk,
    input  logic              reset,
    // Bus master side
    output busPkg::busReq_t   busReq,
    input  logic              waitrequest,
    input  isaPkg::word_t     readdata,
    output logic              active,
    // Register file ports
    output isaPkg::regIndex_t rsIndex,
    output isaPkg::regIndex_t rtIndex,
    input  isaPkg::word_t     rsData,
    input  isaPkg::word_t     rtData,
    output logic              regWrite,
    output isaPkg::regIndex_t writeIndex,
    output isaPkg::word_t     writeData,
    // ALU ports
    output isaPkg::aluOp_t    aluOp,
    output isaPkg::word_t     aluA,
    output isaPkg::word_t     aluB,
    output isaPkg::shamt_t    shamt,
    input  isaPkg::word_t     aluResult
);
    import isaPkg::*;

    typedef enum logic [1:0] {
        FETCH,
        EXEC,
        MEM,
        HALT
    } cpuState_t;

    cpuState_t   state;
    word_t       pc;
    word_t       ir;
    // Instruction fields
    opcode_t     opcode;
    funct_t      funct;
    regIndex_t   rd;
    logic [15:0] imm;
    logic [25:0] target;
    // Decode results
    logic        useImm;
    logic        signExt;
    logic        varShift;
    logic        destRd;
    logic        writesReg;
    logic        isMem;
    logic        isLoad;
    // Next PC
    word_t       pcPlus4;
    word_t       branchTarget;
    word_t       jumpTarget;
    word_t       nextPc;
    logic        haltNext;

    // Field split
    assign opcode  = opcode_t'(ir[31:26]);
    assign rsIndex = ir[25:21];
    assign rtIndex = ir[20:16];
    assign rd      = ir[15:11];
    assign imm     = ir[15:0];
    assign funct   = funct_t'(ir[5:0]);
    assign target  = ir[25:0];

    // Opcode and funct to ALU op, operand and destination selects
    always_comb begin
        aluOp     = ALU_ADD;
        useImm    = 1'b1;
        signExt   = 1'b1;
        varShift  = 1'b0;
        destRd    = 1'b0;
        writesReg = 1'b0;
        isMem     = 1'b0;
        isLoad    = 1'b0;
        case (opcode)
            OP_R: begin
                useImm    = 1'b0;
                destRd    = 1'b1;
                writesReg = 1'b1;
                varShift  = (funct == FN_SLLV) || (funct == FN_SRLV) || (funct == FN_SRAV);
                case (funct)
                    FN_ADDU:          aluOp = ALU_ADD;
                    FN_SUBU:          aluOp = ALU_SUB;
                    FN_AND:           aluOp = ALU_AND;
                    FN_OR:            aluOp = ALU_OR;
                    FN_XOR:           aluOp = ALU_XOR;
                    FN_SLT:           aluOp = ALU_SLT;
                    FN_SLTU:          aluOp = ALU_SLTU;
                    FN_SLL, FN_SLLV:  aluOp = ALU_SLL;
                    FN_SRL, FN_SRLV:  aluOp = ALU_SRL;
                    FN_SRA, FN_SRAV:  aluOp = ALU_SRA;
                    // JR and unknown codes write nothing
                    default:          writesReg = 1'b0;
                endcase
            end
            OP_ADDIU: writesReg = 1'b1;
            OP_SLTI: begin
                aluOp     = ALU_SLT;
                writesReg = 1'b1;
            end
            // Immediate sign extended, then compared unsigned
            OP_SLTIU: begin
                aluOp     = ALU_SLTU;
                writesReg = 1'b1;
            end
            OP_ANDI: begin
                aluOp     = ALU_AND;
                signExt   = 1'b0;
                writesReg = 1'b1;
            end
            OP_ORI: begin
                aluOp     = ALU_OR;
                signExt   = 1'b0;
                writesReg = 1'b1;
            end
            OP_XORI: begin
                aluOp     = ALU_XOR;
                signExt   = 1'b0;
                writesReg = 1'b1;
            end
            OP_LUI: begin
                aluOp     = ALU_LUI;
                writesReg = 1'b1;
            end
            // Address is rs plus sign extended offset via ALU_ADD
            OP_LW: begin
                isMem  = 1'b1;
                isLoad = 1'b1;
            end
            OP_SW:   isMem = 1'b1;
            default: useImm = 1'b0;
        endcase
    end

    // ALU operands
    assign aluA  = rsData;
    assign aluB  = !useImm ? rtData
                 : signExt ? {{16{imm[15]}}, imm}
                 : {16'h0000, imm};
    assign shamt = varShift ? rsData[4:0] : ir[10:6];

    // Branch offset counts from PC + 4, as in standard MIPS
    assign pcPlus4      = pc + 32'd4;
    assign branchTarget = pcPlus4 + {{14{imm[15]}}, imm, 2'b00};
    assign jumpTarget   = {pcPlus4[31:28], target, 2'b00};

    always_comb begin
        nextPc = pcPlus4;
        case (opcode)
            OP_J:   nextPc = jumpTarget;
            OP_BEQ: nextPc = (rsData == rtData) ? branchTarget : pcPlus4;
            OP_BNE: nextPc = (rsData != rtData) ? branchTarget : pcPlus4;
            OP_R:   nextPc = (funct == FN_JR) ? rsData : pcPlus4;
            default: nextPc = pcPlus4;
        endcase
    end

    // JR to $zero lands here
    assign haltNext = (nextPc == `HALT_ADDRESS);

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= FETCH;
            pc    <= `RESET_VECTOR;
        end else begin
            case (state)
                FETCH: begin
                    if (!waitrequest) begin
                        state <= EXEC;
                    end
                end
                // Memory ops keep the old PC until MEM completes
                EXEC: begin
                    if (isMem) begin
                        state <= MEM;
                    end else begin
                        pc    <= nextPc;
                        state <= haltNext ? HALT : FETCH;
                    end
                end
                MEM: begin
                    if (!waitrequest) begin
                        pc    <= nextPc;
                        state <= haltNext ? HALT : FETCH;
                    end
                end
                // Stuck until reset
                default: state <= HALT;
            endcase
        end
    end

    // Instruction register, loads on fetch completion
    always_ff @(posedge clk) begin
        if ((state == FETCH) && !waitrequest) begin
            ir <= readdata;
        end
    end

    // Bus request from state, held as long as state holds
    always_comb begin
        busReq.address    = pc;
        busReq.read       = 1'b0;
        busReq.write      = 1'b0;
        busReq.writedata  = rtData;
        busReq.byteenable = '1;
        case (state)
            FETCH: busReq.read = 1'b1;
            MEM: begin
                busReq.address = aluResult;
                busReq.read    = isLoad;
                busReq.write   = !isLoad;
            end
            default: busReq.read = 1'b0;
        endcase
    end

    assign active = (state != HALT);

    // ALU results in EXEC, load data on the MEM completion edge
    assign regWrite   = ((state == EXEC) && writesReg)
                     || ((state == MEM) && isLoad && !waitrequest);
    assign writeIndex = destRd ? rd : rtIndex;
    assign writeData  = (state == MEM) ? readdata : aluResult;

    // Never a read and a write in the same cycle
    assert property (@(posedge clk) disable iff (reset)
        !(busReq.read && busReq.write));

    // Stalled request held unchanged until accepted
    assert property (@(posedge clk) disable iff (reset)
        (busReq.read || busReq.write) && waitrequest |=> $stable(busReq));

    // Word-only bus, no lane steering
    assert property (@(posedge clk) disable iff (reset)
        (busReq.read || busReq.write) |-> (busReq.address[1:0] == 2'b00));

    // Catches programs writing $zero
    assert property (@(posedge clk) disable iff (reset)
        regWrite |-> (writeIndex != '0));

endmodule

//--- cpu_params.svh
/* Core-wide constants. The reset vector must be word aligned, and a PC equal to
   the halt address stops the core instead of fetching */
`ifndef CPU_PARAMS_SVH
`define CPU_PARAMS_SVH

// First fetch after reset, MIPS boot ROM base
`define RESET_VECTOR 32'hBFC00000

// Jumping here ends the program
`define HALT_ADDRESS 32'h00000000

// Data path width
`define WORD_WIDTH 32

// General purpose registers, register 0 hardwired to zero
`define REG_COUNT 32

`endif

//--- cpu_vectors.hex
// Header: program words, data words, expected stores, expected v0
// Then program words, data words, and expected store pairs (address data)
00000044 00000002 00000019 1234571D
// Setup: base 0x1000 in $8, a = -7 in $9, b = 0x13 in $10
24081000 2409FFF9 340A0013
// ALU results stored to 0x1040 upward
012A5821 AD0B0040 01495823 AD0B0044 012A5824 AD0B0048 012A5825 AD0B004C
012A5826 AD0B0050 012A582A AD0B0054 012A582B AD0B0058 000A5900 AD0B005C
00095902 AD0B0060 00095903 AD0B0064 01495804 AD0B0068 01495806 AD0B006C
01495807 AD0B0070 312BF0F0 AD0B0074 392B00FF AD0B0078 292BFFFF AD0B007C
2D4BFFFF AD0B0080 3C0BBEEF AD0B0084
// Load, add, store back, reload and store again
8D0C0000 8D0D0004 018D5821 AD0B0000 8D0E0000 AD0E0008
// BEQ not taken, BEQ taken, BNE not taken, BNE taken, J
118D0001 340F00A1 AD0F0010 118C0002 340F0BAD AD0F0014 340F00A2 AD0F0014
158C0002 340F00A3 AD0F0018 158D0002 340F0BAD AD0F001C 340F00A4 AD0F001C
0BF00040 340F0BAD AD0F0020 340F00A5 AD0F0020
// v0 = marker + loaded word, then JR $0
01EC1021 00000008
// Data words at 0x1000
12345678 0F0F0F0F
// Expected stores
00001040 0000000C 00001044 0000001A 00001048 00000011 0000104C FFFFFFFB
00001050 FFFFFFEA 00001054 00000001 00001058 00000000 0000105C 00000130
00001060 0FFFFFFF 00001064 FFFFFFFF 00001068 FFC80000 0000106C 00001FFF
00001070 FFFFFFFF 00001074 0000F0F0 00001078 FFFFFF06 0000107C 00000001
00001080 00000001 00001084 BEEF0000 00001000 21436587 00001008 21436587
00001010 000000A1 00001014 000000A2 00001018 000000A3 0000101C 000000A4
00001020 000000A5

//--- filelist.f
+incdir+.
isaPkg.sv
busPkg.sv
regFile.sv
alu.sv
controlUnit.sv
mipsCpuBus.sv
busChecker.sv
mipsCpuBus_tb.sv

//--- isaPkg.sv
/* Kept MIPS subset only. Codes outside these enums decode as no-ops */
`include "cpu_params.svh"

package isaPkg;

    // Data and address word
    typedef logic [`WORD_WIDTH-1:0] word_t;
    // Register number, 0 to 31
    typedef logic [4:0] regIndex_t;
    // Shift amount field or low bits of rs
    typedef logic [4:0] shamt_t;

    // Primary opcode, instruction bits 31:26
    typedef enum logic [5:0] {
        OP_R     = 6'd0,
        OP_J     = 6'd2,
        OP_BEQ   = 6'd4,
        OP_BNE   = 6'd5,
        OP_ADDIU = 6'd9,
        OP_SLTI  = 6'd10,
        OP_SLTIU = 6'd11,
        OP_ANDI  = 6'd12,
        OP_ORI   = 6'd13,
        OP_XORI  = 6'd14,
        OP_LUI   = 6'd15,
        OP_LW    = 6'd35,
        OP_SW    = 6'd43
    } opcode_t;

    // R-type function code, bits 5:0
    typedef enum logic [5:0] {
        FN_SLL  = 6'd0,
        FN_SRL  = 6'd2,
        FN_SRA  = 6'd3,
        FN_SLLV = 6'd4,
        FN_SRLV = 6'd6,
        FN_SRAV = 6'd7,
        FN_JR   = 6'd8,
        FN_ADDU = 6'd33,
        FN_SUBU = 6'd35,
        FN_AND  = 6'd36,
        FN_OR   = 6'd37,
        FN_XOR  = 6'd38,
        FN_SLT  = 6'd42,
        FN_SLTU = 6'd43
    } funct_t;

    // ALU function select
    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLT,
        ALU_SLTU,
        ALU_SLL,
        ALU_SRL,
        ALU_SRA,
        ALU_LUI
    } aluOp_t;

endpackage

//--- mipsCpuBus.sv
/* Multicycle MIPS core with an Avalon master; full words only, byteenable is
   always all ones. active falls once the PC reaches zero */
`timescale 1ns/10ps

module mipsCpuBus (
    input  logic                clk,
    input  logic                reset,
    output logic                active,
    output isaPkg::word_t       register_v0,
    // Avalon master
    output isaPkg::word_t       address,
    output logic                write,
    output logic                read,
    input  logic                waitrequest,
    output isaPkg::word_t       writedata,
    output busPkg::byteEnable_t byteenable,
    input  isaPkg::word_t       readdata
);
    import isaPkg::*;
    import busPkg::*;

    busReq_t   busReq;
    // Register file links
    regIndex_t rsIndex;
    regIndex_t rtIndex;
    word_t     rsData;
    word_t     rtData;
    logic      regWrite;
    regIndex_t writeIndex;
    word_t     writeData;
    // ALU links
    aluOp_t    aluOp;
    word_t     aluA;
    word_t     aluB;
    shamt_t    shamt;
    word_t     aluResult;

    controlUnit controlUnit_i (
        .clk        (clk),
        .reset      (reset),
        .busReq     (busReq),
        .waitrequest(waitrequest),
        .readdata   (readdata),
        .active     (active),
        .rsIndex    (rsIndex),
        .rtIndex    (rtIndex),
        .rsData     (rsData),
        .rtData     (rtData),
        .regWrite   (regWrite),
        .writeIndex (writeIndex),
        .writeData  (writeData),
        .aluOp      (aluOp),
        .aluA       (aluA),
        .aluB       (aluB),
        .shamt      (shamt),
        .aluResult  (aluResult)
    );

    regFile regFile_i (
        .clk       (clk),
        .reset     (reset),
        .rsIndex   (rsIndex),
        .rtIndex   (rtIndex),
        .rsData    (rsData),
        .rtData    (rtData),
        .regWrite  (regWrite),
        .writeIndex(writeIndex),
        .writeData (writeData),
        .v0        (register_v0)
    );

    alu alu_i (
        .aluOp (aluOp),
        .a     (aluA),
        .b     (aluB),
        .shamt (shamt),
        .result(aluResult)
    );

    // Request struct out to the named bus ports
    assign address    = busReq.address;
    assign read       = busReq.read;
    assign write      = busReq.write;
    assign writedata  = busReq.writedata;
    assign byteenable = busReq.byteenable;

endmodule

//--- mipsCpuBus_tb.sv
/* Program memory at the reset vector, 64 data words at 0x1000. Each transfer
   is stretched by 0 to 3 random wait cycles */
`timescale 1ns/10ps
`include "cpu_params.svh"

module mipsCpuBus_tb;
    import isaPkg::*;
    import busPkg::*;

    logic        clk;
    logic        reset;
    logic        waitrequest;
    word_t       readdata;
    logic        active;
    word_t       register_v0;
    word_t       address;
    word_t       writedata;
    logic        write;
    logic        read;
    byteEnable_t byteenable;
    busReq_t     monReq;

    word_t       vec [0:255];
    word_t       progMem [0:127];
    word_t       dataMem [0:63];
    int          checkCount;
    int          errorCount;
    logic        done;
    int          cycles;
    int          limit;
    int          stallLeft;
    logic        inTransfer;

    mipsCpuBus dut_i (
        .clk        (clk),
        .reset      (reset),
        .active     (active),
        .register_v0(register_v0),
        .address    (address),
        .write      (write),
        .read       (read),
        .waitrequest(waitrequest),
        .writedata  (writedata),
        .byteenable (byteenable),
        .readdata   (readdata)
    );

    assign monReq = {address, read, write, writedata, byteenable};

    busChecker busChecker_i (
        .clk        (clk),
        .reset      (reset),
        .busReq     (monReq),
        .waitrequest(waitrequest),
        .active     (active),
        .register_v0(register_v0),
        .vec        (vec),
        .checkCount (checkCount),
        .errorCount (errorCount),
        .done       (done)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // Boot ROM window or data window, anything else reads a marker
    function automatic word_t memRead(input word_t addr);
        if (addr[31:12] == 20'hBFC00) begin
            return progMem[addr[8:2]];
        end else if (addr[31:8] == 24'h000010) begin
            return dataMem[addr[7:2]];
        end
        return 32'hBAD0BAD0;
    endfunction

    initial begin
        reset       = 1'b1;
        waitrequest = 1'b1;
        readdata    = '0;
        cycles      = 0;
        limit       = 100000;
        void'($urandom(32'habe3e529));
        $readmemh("cpu_vectors.hex", vec);
        // Fill patterns tied to the full address
        for (int i = 0; i < 128; i++) begin
            progMem[i] = 32'hDEAD0000 ^ (`RESET_VECTOR + 32'(i * 4));
        end
        for (int i = 0; i < 64; i++) begin
            dataMem[i] = 32'hDA7A0000 ^ (32'h00001000 + 32'(i * 4));
        end
        // Header is program length, data count, store count, v0
        for (int i = 0; i < int'(vec[0]); i++) begin
            progMem[i] = vec[4 + i];
        end
        for (int i = 0; i < int'(vec[1]); i++) begin
            dataMem[i] = vec[4 + int'(vec[0]) + i];
        end
        limit = (int'(vec[0]) * 3 + int'(vec[2]) * 4) * 4 + 50;
        repeat (2) @(posedge clk);
        #5 reset = 1'b0;

        wait (done);
        // A few more cycles to see the bus stay quiet
        repeat (3) @(posedge clk);
        $display("checks %0d, errors %0d", checkCount, errorCount);
        if (errorCount == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

    // Avalon slave, fresh random stall for every transfer
    initial begin
        inTransfer = 1'b0;
        stallLeft  = 0;
        wait (!reset);
        forever begin
            @(posedge clk);
            #5;
            if (read || write) begin
                if (!inTransfer) begin
                    inTransfer = 1'b1;
                    stallLeft  = int'($urandom % 4);
                end
                if (stallLeft > 0) begin
                    waitrequest = 1'b1;
                    stallLeft--;
                end else begin
                    // Accepted at the next rising edge
                    waitrequest = 1'b0;
                    inTransfer  = 1'b0;
                    if (read) begin
                        readdata = memRead(address);
                    end else if (address[31:8] == 24'h000010) begin
                        dataMem[address[7:2]] = writedata;
                    end
                end
            end else begin
                waitrequest = 1'b1;
            end
        end
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= limit) begin
            $display("timeout: core did not halt within %0d cycles", limit);
            $display("checks %0d, errors %0d", checkCount, errorCount + 1);
            $display("** FAIL **");
            $finish;
        end
    end

endmodule

//--- regFile.sv
/* Combinational reads, write visible next cycle. Writes to register 0 are
   dropped so it always reads zero */
`timescale 1ns/10ps
`include "cpu_params.svh"

module regFile (
    input  logic              clk,
    input  logic              reset,
    // Two read ports for rs and rt
    input  isaPkg::regIndex_t rsIndex,
    input  isaPkg::regIndex_t rtIndex,
    output isaPkg::word_t     rsData,
    output isaPkg::word_t     rtData,
    // Single write port
    input  logic              regWrite,
    input  isaPkg::regIndex_t writeIndex,
    input  isaPkg::word_t     writeData,
    // Register 2, result register seen at the top level
    output isaPkg::word_t     v0
);
    import isaPkg::*;

    word_t regs [`REG_COUNT];

    always_ff @(posedge clk) begin
        if (reset) begin
            // Whole file starts at zero
            for (int i = 0; i < `REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (regWrite && (writeIndex != '0)) begin
            regs[writeIndex] <= writeData;
        end
    end

    // No bypass, a value written this cycle shows up next cycle
    assign rsData = regs[rsIndex];
    assign rtData = regs[rtIndex];

    // $v0
    assign v0 = regs[2];

endmodule

//--- run.sh
#!/usr/bin/env bash
# Builds the core and testbench with Verilator, runs it, checks the log

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f filelist.f --top-module mipsCpuBus_tb -o simv
status=$?
if [ $status -ne 0 ]; then
    echo "build failed with status $status"
    exit 1
fi

./obj_dir/simv > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "\*\* FAIL \*\*" sim.log; then
    exit 1
fi
if ! grep -q "\*\* PASS \*\*" sim.log; then
    echo "simulation ended without a result"
    exit 1
fi
exit 0
